// File: source/soc_map_pkg.sv
package soc_map_pkg;

  // Bus address, seen as a region/offset pair or as one word
  typedef union packed {
    struct packed {
      logic [7:0]  region;
      logic [23:0] offset;
    } map;
    logic [31:0] raw;
  } soc_addr_u;

  // Region codes held in address bits 31:24
  localparam logic [7:0] REGION_SRAM    = 8'h00;
  localparam logic [7:0] REGION_UART0   = 8'h10;
  localparam logic [7:0] REGION_UART1   = 8'h11;
  localparam logic [7:0] REGION_ENCODER = 8'h12;
  localparam logic [7:0] REGION_SWITCH  = 8'h13;

  // One-hot device select vector
  localparam int SEL_WIDTH = 5;

  localparam int SEL_SRAM    = 0;
  localparam int SEL_UART0   = 1;
  localparam int SEL_UART1   = 2;
  localparam int SEL_ENCODER = 3;
  localparam int SEL_SWITCH  = 4;

endpackage

// File: source/soc_io_pkg.sv
package soc_io_pkg;

  // UART register word offsets (address bits 2:1)
  localparam logic [1:0] UART_REG_DATA   = 2'd0;
  localparam logic [1:0] UART_REG_STATUS = 2'd1;
  localparam logic [1:0] UART_REG_DIV    = 2'd2;

  // Encoder register word offsets
  localparam logic [1:0] ENC_REG_POS    = 2'd0;
  localparam logic [1:0] ENC_REG_STATUS = 2'd1;
  localparam logic [1:0] ENC_REG_RGB    = 2'd2;

  // UART status bits
  localparam int STAT_TX_BUSY    = 0;
  localparam int STAT_RX_VALID   = 1;
  localparam int STAT_RX_OVERRUN = 2;

  // Encoder status bits
  localparam int ENC_STAT_BUTTON = 0;

  // Detent count of one encoder turn
  localparam int ENC_POSITIONS = 24;

endpackage

// File: source/mem_select.sv
`timescale 1ns/10ps

module mem_select (
  input  logic                               clock_50,
  input  soc_map_pkg::soc_addr_u             addr,
  output logic [soc_map_pkg::SEL_WIDTH-1:0]  sel
);

  import soc_map_pkg::*;

  logic [7:0] region;

  assign region = addr.map.region;

  // Only the top byte takes part in the decode
  always_comb begin
    sel = '0;
    case (region)
      REGION_SRAM: begin
        sel[SEL_SRAM] = 1'b1;
      end
      REGION_UART0: begin
        sel[SEL_UART0] = 1'b1;
      end
      REGION_UART1: begin
        sel[SEL_UART1] = 1'b1;
      end
      REGION_ENCODER: begin
        sel[SEL_ENCODER] = 1'b1;
      end
      REGION_SWITCH: begin
        sel[SEL_SWITCH] = 1'b1;
      end
      default: begin
        sel = '0;
      end
    endcase
  end

  // The read mux ORs the selected devices, so two at once would corrupt cpu_rdata
  sel_onehot: assert property (@(posedge clock_50) $onehot0(sel))
    else $error("mem_select: more than one device selected, sel=%b", sel);

endmodule

// File: source/uart.sv
`timescale 1ns/10ps

module uart #(
  parameter int unsigned DIV_RESET = 16
) (
  input  logic        clock_50,
  input  logic        rst_n,
  input  logic        write,
  input  logic [1:0]  address,
  input  logic [15:0] data_in,
  output logic [15:0] data_out,
  input  logic        rx,
  output logic        tx
);

  import soc_io_pkg::*;

  logic [15:0] div;
  logic        data_write;
  logic        status_write;
  logic        div_write;

  // Transmitter
  logic        tx_busy;
  logic [9:0]  tx_shift;
  logic [15:0] tx_cnt;
  logic [3:0]  tx_bit;

  // Receiver
  logic        rx_meta;
  logic        rx_sync;
  logic        rx_last;
  logic        rx_busy;
  logic [15:0] rx_cnt;
  logic [3:0]  rx_bit;
  logic [7:0]  rx_shift;
  logic [7:0]  rx_data;
  logic        rx_valid;
  logic        rx_overrun;
  logic        rx_tick;
  logic        rx_done;
  logic [15:0] half_div;

  assign data_write   = write && (address == UART_REG_DATA);
  assign status_write = write && (address == UART_REG_STATUS);
  assign div_write    = write && (address == UART_REG_DIV);

  always_ff @(posedge clock_50) begin
    if (!rst_n) begin
      div <= 16'(DIV_RESET);
    end else if (div_write) begin
      // Below 2 the half-bit count would underflow
      div <= (data_in < 16'd2) ? 16'd2 : data_in;
    end
  end

  // Frame is stop, data LSB first, start; shifted out from bit 0
  always_ff @(posedge clock_50) begin
    if (!rst_n) begin
      tx_busy  <= 1'b0;
      tx_shift <= '1;
      tx_cnt   <= '0;
      tx_bit   <= '0;
    end else if (!tx_busy) begin
      if (data_write) begin
        tx_busy  <= 1'b1;
        tx_shift <= {1'b1, data_in[7:0], 1'b0};
        tx_cnt   <= '0;
        tx_bit   <= '0;
      end
    end else if (tx_cnt >= div - 16'd1) begin
      tx_cnt   <= '0;
      tx_shift <= {1'b1, tx_shift[9:1]};
      if (tx_bit == 4'd9) begin
        tx_busy <= 1'b0;
        tx_bit  <= '0;
      end else begin
        tx_bit <= tx_bit + 4'd1;
      end
    end else begin
      tx_cnt <= tx_cnt + 16'd1;
    end
  end

  assign tx = tx_shift[0];

  always_ff @(posedge clock_50) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_last <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_last <= rx_sync;
    end
  end

  assign half_div = {1'b0, div[15:1]} - 16'd1;
  assign rx_tick  = rx_busy && (rx_cnt == 16'd0);
  assign rx_done  = rx_tick && (rx_bit == 4'd9) && rx_sync;

  always_ff @(posedge clock_50) begin
    if (!rst_n) begin
      rx_busy    <= 1'b0;
      rx_cnt     <= '0;
      rx_bit     <= '0;
      rx_valid   <= 1'b0;
      rx_overrun <= 1'b0;
    end else begin
      if (status_write) begin
        rx_valid   <= 1'b0;
        rx_overrun <= 1'b0;
      end
      if (!rx_busy) begin
        if (rx_last && !rx_sync) begin
          rx_busy <= 1'b1;
          rx_cnt  <= half_div;
          rx_bit  <= '0;
        end
      end else if (!rx_tick) begin
        rx_cnt <= rx_cnt - 16'd1;
      end else begin
        rx_cnt <= div - 16'd1;
        if (rx_bit == 4'd0) begin
          // Start bit gone high again at mid-bit, treat as a glitch
          if (rx_sync) begin
            rx_busy <= 1'b0;
          end
          rx_bit <= 4'd1;
        end else if (rx_bit == 4'd9) begin
          rx_busy <= 1'b0;
          rx_bit  <= '0;
        end else begin
          rx_bit <= rx_bit + 4'd1;
        end
      end
      // Frames with a low stop bit are dropped
      if (rx_done) begin
        rx_valid   <= 1'b1;
        rx_overrun <= rx_valid && !status_write;
      end
    end
  end

  always_ff @(posedge clock_50) begin
    if (rx_tick && (rx_bit != 4'd0) && (rx_bit != 4'd9)) begin
      rx_shift <= {rx_sync, rx_shift[7:1]};
    end
    if (rx_done) begin
      rx_data <= rx_shift;
    end
  end

  always_comb begin
    data_out = '0;
    case (address)
      UART_REG_DATA: begin
        data_out = {8'h00, rx_data};
      end
      UART_REG_STATUS: begin
        data_out[STAT_TX_BUSY]    = tx_busy;
        data_out[STAT_RX_VALID]   = rx_valid;
        data_out[STAT_RX_OVERRUN] = rx_overrun;
      end
      UART_REG_DIV: begin
        data_out = div;
      end
      default: begin
        data_out = '0;
      end
    endcase
  end

  bit_index_range: assert property (@(posedge clock_50) disable iff (!rst_n)
    (tx_bit <= 4'd9) && (rx_bit <= 4'd9))
    else $error("uart: bit index out of range, tx_bit=%0d rx_bit=%0d", tx_bit, rx_bit);

endmodule

// File: source/rgb_enc.sv
`timescale 1ns/10ps

module rgb_enc (
  input  logic        clock_50,
  input  logic        rst_n,
  input  logic [1:0]  quad,
  input  logic        button,
  input  logic        write,
  input  logic [1:0]  address,
  input  logic [15:0] data_in,
  output logic [15:0] data_out,
  output logic [2:0]  rgb_out
);

  import soc_io_pkg::*;

  logic [1:0] quad_meta;
  logic [1:0] quad_sync;
  logic [1:0] quad_prev;
  logic       pb_meta;
  logic       pb_sync;
  logic       pb_last;
  logic       step_fwd;
  logic       step_rev;
  logic [4:0] position;
  logic       pressed;
  logic [2:0] colour;

  always_ff @(posedge clock_50) begin
    if (!rst_n) begin
      quad_meta <= '0;
      quad_sync <= '0;
      quad_prev <= '0;
      pb_meta   <= 1'b0;
      pb_sync   <= 1'b0;
      pb_last   <= 1'b0;
    end else begin
      quad_meta <= quad;
      quad_sync <= quad_meta;
      quad_prev <= quad_sync;
      pb_meta   <= button;
      pb_sync   <= pb_meta;
      pb_last   <= pb_sync;
    end
  end

  // Gray sequence 00 01 11 10 counts up; both bits changing is skipped
  always_comb begin
    step_fwd = 1'b0;
    step_rev = 1'b0;
    case ({quad_prev, quad_sync})
      4'b0001, 4'b0111, 4'b1110, 4'b1000: step_fwd = 1'b1;
      4'b0010, 4'b1011, 4'b1101, 4'b0100: step_rev = 1'b1;
      default: step_fwd = 1'b0;
    endcase
  end

  always_ff @(posedge clock_50) begin
    if (!rst_n) begin
      position <= '0;
      pressed  <= 1'b0;
      colour   <= '0;
    end else begin
      if (write && (address == ENC_REG_POS)) begin
        if (data_in < 16'(ENC_POSITIONS)) begin
          position <= data_in[4:0];
        end
      end else if (step_fwd) begin
        position <= (position == 5'(ENC_POSITIONS - 1)) ? 5'd0 : position + 5'd1;
      end else if (step_rev) begin
        position <= (position == 5'd0) ? 5'(ENC_POSITIONS - 1) : position - 5'd1;
      end
      if (write && (address == ENC_REG_STATUS)) begin
        pressed <= 1'b0;
      end
      // A press in the same cycle as the clear is kept
      if (pb_sync && !pb_last) begin
        pressed <= 1'b1;
      end
      if (write && (address == ENC_REG_RGB)) begin
        colour <= data_in[2:0];
      end
    end
  end

  assign rgb_out = colour;

  always_comb begin
    data_out = '0;
    case (address)
      ENC_REG_POS:    data_out = {11'd0, position};
      ENC_REG_STATUS: data_out[ENC_STAT_BUTTON] = pressed;
      ENC_REG_RGB:    data_out = {13'd0, colour};
      default:        data_out = '0;
    endcase
  end

  position_range: assert property (@(posedge clock_50) disable iff (!rst_n)
    position < 5'(ENC_POSITIONS))
    else $error("rgb_enc: position %0d out of range", position);

endmodule

// File: source/hexdisp.sv
`timescale 1ns/10ps

module hexdisp (
  input  logic [3:0] in,
  output logic [6:0] out
);

  // Active low, bit 0 is segment a
  always_comb begin
    case (in)
      4'h0: out = 7'h40;
      4'h1: out = 7'h79;
      4'h2: out = 7'h24;
      4'h3: out = 7'h30;
      4'h4: out = 7'h19;
      4'h5: out = 7'h12;
      4'h6: out = 7'h02;
      4'h7: out = 7'h78;
      4'h8: out = 7'h00;
      4'h9: out = 7'h10;
      4'hA: out = 7'h08;
      4'hB: out = 7'h03;
      4'hC: out = 7'h46;
      4'hD: out = 7'h21;
      4'hE: out = 7'h06;
      default: out = 7'h0E;
    endcase
  end

endmodule

// File: source/soc_io.sv
`timescale 1ns/10ps

module soc_io #(
  parameter int unsigned UART_DIV_RESET = 16
) (
  input  logic        clock_50,
  input  logic        rst_n,
  input  logic [31:0] cpu_addr,
  input  logic [15:0] cpu_wdata,
  input  logic        cpu_write,
  input  logic        cpu_bytectl,
  output logic [15:0] cpu_rdata,
  input  logic [9:0]  sw,
  output logic [7:0]  ledg,
  output logic [9:0]  ledr,
  output logic [6:0]  hex0,
  output logic [6:0]  hex1,
  output logic [6:0]  hex2,
  output logic [6:0]  hex3,
  output logic [17:0] sram_addr,
  output logic [15:0] sram_wdata,
  input  logic [15:0] sram_rdata,
  output logic        sram_we_n,
  output logic        sram_oe_n,
  output logic        sram_ub_n,
  output logic        sram_lb_n,
  output logic        sram_ce_n,
  input  logic        serial0_rx,
  input  logic        serial1_rx,
  output logic        serial0_tx,
  output logic        serial1_tx,
  input  logic [1:0]  quad,
  input  logic        pb,
  output logic [2:0]  rgb
);

  import soc_map_pkg::*;

  soc_addr_u            addr;
  logic [SEL_WIDTH-1:0] sel;
  logic [1:0]           reg_addr;
  logic [15:0]          uart0_data;
  logic [15:0]          uart1_data;
  logic [15:0]          enc_data;

  assign addr.raw = cpu_addr;
  assign reg_addr = addr.map.offset[2:1];

  mem_select u_mem_select (.clock_50(clock_50), .addr(addr), .sel(sel));

  uart #(.DIV_RESET(UART_DIV_RESET)) uart0 (
    .clock_50(clock_50), .rst_n(rst_n), .write(cpu_write & sel[SEL_UART0]),
    .address(reg_addr), .data_in(cpu_wdata), .data_out(uart0_data),
    .rx(serial0_rx), .tx(serial0_tx));

  uart #(.DIV_RESET(UART_DIV_RESET)) uart1 (
    .clock_50(clock_50), .rst_n(rst_n), .write(cpu_write & sel[SEL_UART1]),
    .address(reg_addr), .data_in(cpu_wdata), .data_out(uart1_data),
    .rx(serial1_rx), .tx(serial1_tx));

  rgb_enc u_rgb_enc (
    .clock_50(clock_50), .rst_n(rst_n), .quad(quad), .button(pb),
    .write(cpu_write & sel[SEL_ENCODER]), .address(reg_addr), .data_in(cpu_wdata),
    .data_out(enc_data), .rgb_out(rgb));

  // AND-OR read mux, nothing selected reads as zero
  assign cpu_rdata = ({16{sel[SEL_SRAM]}}    & sram_rdata)
                   | ({16{sel[SEL_UART0]}}   & uart0_data)
                   | ({16{sel[SEL_UART1]}}   & uart1_data)
                   | ({16{sel[SEL_ENCODER]}} & enc_data)
                   | ({16{sel[SEL_SWITCH]}}  & {8'h00, sw[7:0]});

  // SRAM is word wide, so byte address bit 0 picks the lane
  assign sram_addr  = addr.map.offset[18:1];
  assign sram_wdata = cpu_wdata;
  assign sram_we_n  = ~cpu_write;
  assign sram_oe_n  = ~sram_we_n;
  assign sram_ce_n  = ~sel[SEL_SRAM];
  assign sram_lb_n  = cpu_bytectl & ~addr.map.offset[0];
  assign sram_ub_n  = cpu_bytectl & addr.map.offset[0];

  assign ledg = {{(8 - SEL_WIDTH){1'b0}}, sel};
  assign ledr = {8'h00, cpu_bytectl, cpu_write};

  hexdisp u_hex3 (.in(cpu_wdata[15:12]), .out(hex3));
  hexdisp u_hex2 (.in(cpu_wdata[11:8]), .out(hex2));
  hexdisp u_hex1 (.in(cpu_wdata[7:4]), .out(hex1));
  hexdisp u_hex0 (.in(cpu_wdata[3:0]), .out(hex0));

endmodule

// File: test/clock_gen.sv
`timescale 1ns/10ps

module clock_gen #(
  parameter int RESET_CYCLES = 4
) (
  output logic clock_50,
  output logic rst_n
);

  // 10 ns period
  initial begin
    clock_50 = 1'b0;
    forever #5 clock_50 = ~clock_50;
  end

  initial begin
    rst_n <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clock_50);
    rst_n <= 1'b1;
  end

endmodule

// File: test/soc_io_tb.sv
`timescale 1ns/10ps

module soc_io_tb;

  localparam int DIV_RESET      = 16;
  localparam int UART_DIV       = 4;
  localparam int UART_FRAME     = 10 * UART_DIV;
  localparam int POLL_LIMIT     = 3 * UART_FRAME;
  localparam int UART_BYTES     = 5;
  localparam int ENC_MAX_STEPS  = 31 + 15;
  // A byte can wait out two polls, one on each UART
  localparam int TEST_CYCLES    = 40 + 20 + 20 + UART_BYTES * (2 * POLL_LIMIT + 12)
                                + ENC_MAX_STEPS * 4 + 40;
  localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

  // Memory map regions, plus one that nothing decodes
  localparam logic [7:0] R_SRAM  = 8'h00;
  localparam logic [7:0] R_UART0 = 8'h10;
  localparam logic [7:0] R_UART1 = 8'h11;
  localparam logic [7:0] R_ENC   = 8'h12;
  localparam logic [7:0] R_SW    = 8'h13;
  localparam logic [7:0] R_NONE  = 8'h20;

  logic        clock_50;
  logic        rst_n;
  logic [31:0] cpu_addr;
  logic [15:0] cpu_wdata;
  logic        cpu_write;
  logic        cpu_bytectl;
  logic [15:0] cpu_rdata;
  logic [9:0]  sw;
  logic [7:0]  ledg;
  logic [9:0]  ledr;
  logic [6:0]  hex0;
  logic [6:0]  hex1;
  logic [6:0]  hex2;
  logic [6:0]  hex3;
  logic [17:0] sram_addr;
  logic [15:0] sram_wdata;
  logic [15:0] sram_rdata;
  logic        sram_we_n;
  logic        sram_oe_n;
  logic        sram_ub_n;
  logic        sram_lb_n;
  logic        sram_ce_n;
  logic        serial0_tx;
  logic        serial1_tx;
  logic [1:0]  quad;
  logic        pb;
  logic [2:0]  rgb;

  int          errors;
  int          tests_passed;
  int          tests_failed;
  int          cycles;
  logic [31:0] lfsr;

  clock_gen u_clock_gen (.clock_50(clock_50), .rst_n(rst_n));

  // The two UARTs are cross-wired for loopback
  soc_io #(.UART_DIV_RESET(DIV_RESET)) u_soc_io (
    .clock_50(clock_50), .rst_n(rst_n),
    .cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata), .cpu_write(cpu_write),
    .cpu_bytectl(cpu_bytectl), .cpu_rdata(cpu_rdata),
    .sw(sw), .ledg(ledg), .ledr(ledr),
    .hex0(hex0), .hex1(hex1), .hex2(hex2), .hex3(hex3),
    .sram_addr(sram_addr), .sram_wdata(sram_wdata), .sram_rdata(sram_rdata),
    .sram_we_n(sram_we_n), .sram_oe_n(sram_oe_n), .sram_ub_n(sram_ub_n),
    .sram_lb_n(sram_lb_n), .sram_ce_n(sram_ce_n),
    .serial0_rx(serial1_tx), .serial1_rx(serial0_tx),
    .serial0_tx(serial0_tx), .serial1_tx(serial1_tx),
    .quad(quad), .pb(pb), .rgb(rgb));

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[31]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  function automatic logic [31:0] reg_at(input logic [7:0] region, input logic [1:0] index);
    return {region, 21'd0, index, 1'b0};
  endfunction

  function automatic logic [7:0] expected_sel(input logic [7:0] region);
    case (region)
      R_SRAM:  return 8'h01;
      R_UART0: return 8'h02;
      R_UART1: return 8'h04;
      R_ENC:   return 8'h08;
      R_SW:    return 8'h10;
      default: return 8'h00;
    endcase
  endfunction

  // Active-low font, bit 0 is segment a
  function automatic logic [6:0] seg_pattern(input logic [3:0] nibble);
    case (nibble)
      4'h0: return 7'h40;
      4'h1: return 7'h79;
      4'h2: return 7'h24;
      4'h3: return 7'h30;
      4'h4: return 7'h19;
      4'h5: return 7'h12;
      4'h6: return 7'h02;
      4'h7: return 7'h78;
      4'h8: return 7'h00;
      4'h9: return 7'h10;
      4'hA: return 7'h08;
      4'hB: return 7'h03;
      4'hC: return 7'h46;
      4'hD: return 7'h21;
      4'hE: return 7'h06;
      default: return 7'h0E;
    endcase
  endfunction

  function automatic logic [1:0] gray_code(input int phase);
    case (phase)
      0: return 2'b00;
      1: return 2'b01;
      2: return 2'b11;
      default: return 2'b10;
    endcase
  endfunction

  task automatic check_value(input string test, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected)
      else begin
        $display("ERR %s expected %0h actual %0h", test, expected, actual);
        errors++;
      end
  endtask

  task automatic check_true(input string test, input logic cond, input string what);
    assert (cond)
      else begin
        $display("%s: %s", test, what);
        errors++;
      end
  endtask

  task automatic report_test(input string test, input int errs_before);
    if (errors == errs_before) begin
      tests_passed++;
      $display("%s: done, no errors", test);
    end else begin
      tests_failed++;
      $display("%s: done, %0d errors", test, errors - errs_before);
    end
  endtask

  // Drives one bus cycle and returns at the falling edge, where outputs are settled
  task automatic drive_bus(input logic [31:0] addr, input logic [15:0] wdata,
                           input logic write, input logic bytectl);
    @(posedge clock_50);
    cpu_addr    <= addr;
    cpu_wdata   <= wdata;
    cpu_write   <= write;
    cpu_bytectl <= bytectl;
    @(negedge clock_50);
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [15:0] data);
    drive_bus(addr, data, 1'b1, 1'b0);
    @(posedge clock_50);
    cpu_write <= 1'b0;
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [15:0] data);
    drive_bus(addr, cpu_wdata, 1'b0, 1'b0);
    data = cpu_rdata;
  endtask

  task automatic poll_status(input string test, input logic [31:0] addr, input int bit_pos,
                             input logic want, input string what);
    logic [15:0] status;
    int          polls;
    polls = 0;
    bus_read(addr, status);
    while (status[bit_pos] !== want && polls < POLL_LIMIT) begin
      bus_read(addr, status);
      polls++;
    end
    check_true(test, status[bit_pos] === want, what);
  endtask

  task automatic step_quad(input int phase);
    @(posedge clock_50);
    quad <= gray_code(phase);
    repeat (3) @(posedge clock_50);
  endtask

  task automatic test_reset_defaults();
    logic [15:0] data;
    logic [7:0]  region;
    int          errs;
    errs = errors;
    for (int u = 0; u < 2; u++) begin
      region = (u == 0) ? R_UART0 : R_UART1;
      bus_read(reg_at(region, 2'd1), data);
      check_value("reset_defaults", 32'd0, 32'(data));
      bus_read(reg_at(region, 2'd2), data);
      check_value("reset_defaults", 32'(DIV_RESET), 32'(data));
    end
    for (int r = 0; r < 3; r++) begin
      bus_read(reg_at(R_ENC, 2'(r)), data);
      check_value("reset_defaults", 32'd0, 32'(data));
    end
    check_value("reset_defaults", 32'd1, 32'(serial0_tx));
    check_value("reset_defaults", 32'd1, 32'(serial1_tx));
    check_value("reset_defaults", 32'd0, 32'(rgb));
    report_test("reset_defaults", errs);
  endtask

  task automatic test_decode();
    logic [7:0]  regions [6];
    logic [31:0] offset;
    logic [31:0] value;
    logic [15:0] rdata_val;
    logic [9:0]  sw_val;
    logic        bytectl;
    int          errs;
    errs = errors;
    regions = '{R_SRAM, R_UART0, R_UART1, R_ENC, R_SW, R_NONE};
    foreach (regions[i]) begin
      draw_bits(24, offset);
      draw_bits(1, value);
      bytectl = value[0];
      draw_bits(16, value);
      rdata_val = value[15:0];
      draw_bits(10, value);
      sw_val = value[9:0];
      @(posedge clock_50);
      cpu_addr    <= {regions[i], offset[23:0]};
      cpu_write   <= 1'b0;
      cpu_bytectl <= bytectl;
      sram_rdata  <= rdata_val;
      sw          <= sw_val;
      @(negedge clock_50);
      check_value("decode", 32'(expected_sel(regions[i])), 32'(ledg));
      check_value("decode", 32'(regions[i] != R_SRAM), 32'(sram_ce_n));
      check_value("decode", 32'(offset[18:1]), 32'(sram_addr));
      check_value("decode", 32'(bytectl & ~offset[0]), 32'(sram_lb_n));
      check_value("decode", 32'(bytectl & offset[0]), 32'(sram_ub_n));
      check_value("decode", 32'(2'b10), 32'({sram_we_n, sram_oe_n}));
      check_value("decode", 32'({bytectl, 1'b0}), 32'(ledr));
      case (regions[i])
        R_SRAM: check_value("decode", 32'(rdata_val), 32'(cpu_rdata));
        R_SW:   check_value("decode", 32'({8'h00, sw_val[7:0]}), 32'(cpu_rdata));
        R_NONE: check_value("decode", 32'd0, 32'(cpu_rdata));
        default: ;
      endcase
    end
    // SRAM write cycle with byte control on an even address
    drive_bus({R_SRAM, 24'h000124}, 16'hA5C3, 1'b1, 1'b1);
    check_value("decode", 32'h1, 32'({sram_we_n, sram_oe_n}));
    check_value("decode", 32'hA5C3, 32'(sram_wdata));
    check_value("decode", 32'h92, 32'(sram_addr));
    check_value("decode", 32'h3, 32'(ledr));
    check_value("decode", 32'h2, 32'({sram_lb_n, sram_ub_n}));
    @(posedge clock_50);
    cpu_write   <= 1'b0;
    cpu_bytectl <= 1'b0;
    report_test("decode", errs);
  endtask

  task automatic test_hex_display();
    logic [31:0] value;
    int          errs;
    errs = errors;
    for (int i = 0; i < 8; i++) begin
      draw_bits(16, value);
      drive_bus({R_NONE, 24'h0}, value[15:0], 1'b1, 1'b0);
      check_value("hex_display", 32'(seg_pattern(value[15:12])), 32'(hex3));
      check_value("hex_display", 32'(seg_pattern(value[11:8])), 32'(hex2));
      check_value("hex_display", 32'(seg_pattern(value[7:4])), 32'(hex1));
      check_value("hex_display", 32'(seg_pattern(value[3:0])), 32'(hex0));
    end
    @(posedge clock_50);
    cpu_write <= 1'b0;
    report_test("hex_display", errs);
  endtask

  task automatic test_uart_loopback();
    logic [31:0] value;
    logic [15:0] data;
    int          errs;
    errs = errors;
    bus_write(reg_at(R_UART0, 2'd2), 16'(UART_DIV));
    bus_write(reg_at(R_UART1, 2'd2), 16'(UART_DIV));
    bus_read(reg_at(R_UART1, 2'd2), data);
    check_value("uart_loopback", 32'(UART_DIV), 32'(data));
    for (int i = 0; i < 3; i++) begin
      draw_bits(8, value);
      bus_write(reg_at(R_UART0, 2'd0), {8'h00, value[7:0]});
      bus_read(reg_at(R_UART0, 2'd1), data);
      check_value("uart_loopback", 32'h1, 32'(data));
      poll_status("uart_loopback", reg_at(R_UART1, 2'd1), 1, 1'b1,
                  "uart1 never flagged a received byte");
      bus_read(reg_at(R_UART1, 2'd0), data);
      check_value("uart_loopback", 32'(value[7:0]), 32'(data));
      bus_read(reg_at(R_UART1, 2'd1), data);
      check_value("uart_loopback", 32'h2, 32'(data));
      bus_write(reg_at(R_UART1, 2'd1), 16'h0000);
      bus_read(reg_at(R_UART1, 2'd1), data);
      check_value("uart_loopback", 32'h0, 32'(data));
      poll_status("uart_loopback", reg_at(R_UART0, 2'd1), 0, 1'b0, "uart0 stayed busy");
    end
    // Two bytes with no clear between them
    draw_bits(8, value);
    bus_write(reg_at(R_UART0, 2'd0), {8'h00, value[7:0]});
    poll_status("uart_loopback", reg_at(R_UART0, 2'd1), 0, 1'b0, "uart0 stayed busy");
    draw_bits(8, value);
    bus_write(reg_at(R_UART0, 2'd0), {8'h00, value[7:0]});
    poll_status("uart_loopback", reg_at(R_UART0, 2'd1), 0, 1'b0, "uart0 stayed busy");
    poll_status("uart_loopback", reg_at(R_UART1, 2'd1), 2, 1'b1,
                "uart1 never flagged an overrun");
    bus_read(reg_at(R_UART1, 2'd0), data);
    check_value("uart_loopback", 32'(value[7:0]), 32'(data));
    bus_read(reg_at(R_UART1, 2'd1), data);
    check_value("uart_loopback", 32'h6, 32'(data));
    bus_write(reg_at(R_UART1, 2'd1), 16'h0000);
    bus_read(reg_at(R_UART1, 2'd1), data);
    check_value("uart_loopback", 32'h0, 32'(data));
    report_test("uart_loopback", errs);
  endtask

  task automatic test_encoder();
    logic [31:0] value;
    logic [15:0] data;
    int          n_fwd;
    int          n_rev;
    int          phase;
    int          expected;
    int          errs;
    errs = errors;
    draw_bits(5, value);
    n_fwd = int'(value[4:0]);
    draw_bits(4, value);
    n_rev = int'(value[3:0]);
    phase = 0;
    for (int i = 0; i < n_fwd; i++) begin
      phase = (phase + 1) % 4;
      step_quad(phase);
    end
    for (int i = 0; i < n_rev; i++) begin
      phase = (phase + 3) % 4;
      step_quad(phase);
    end
    // Let the last step pass the synchronizer
    repeat (4) @(posedge clock_50);
    expected = ((n_fwd - n_rev) % 24 + 24) % 24;
    bus_read(reg_at(R_ENC, 2'd0), data);
    check_value("encoder", 32'(expected), 32'(data));
    bus_write(reg_at(R_ENC, 2'd0), 16'd30);
    bus_read(reg_at(R_ENC, 2'd0), data);
    check_value("encoder", 32'(expected), 32'(data));
    bus_write(reg_at(R_ENC, 2'd0), 16'd7);
    bus_read(reg_at(R_ENC, 2'd0), data);
    check_value("encoder", 32'd7, 32'(data));
    @(posedge clock_50);
    pb <= 1'b1;
    repeat (4) @(posedge clock_50);
    pb <= 1'b0;
    repeat (2) @(posedge clock_50);
    bus_read(reg_at(R_ENC, 2'd1), data);
    check_value("encoder", 32'd1, 32'(data));
    bus_write(reg_at(R_ENC, 2'd1), 16'h0000);
    bus_read(reg_at(R_ENC, 2'd1), data);
    check_value("encoder", 32'd0, 32'(data));
    draw_bits(3, value);
    bus_write(reg_at(R_ENC, 2'd2), {13'd0, value[2:0]});
    @(negedge clock_50);
    check_value("encoder", 32'(value[2:0]), 32'(rgb));
    bus_read(reg_at(R_ENC, 2'd2), data);
    check_value("encoder", 32'(value[2:0]), 32'(data));
    report_test("encoder", errs);
  endtask

  initial begin
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    lfsr         = 32'h6e2;
    cpu_addr    <= '0;
    cpu_wdata   <= '0;
    cpu_write   <= 1'b0;
    cpu_bytectl <= 1'b0;
    sw          <= '0;
    sram_rdata  <= '0;
    quad        <= 2'b00;
    pb          <= 1'b0;
    wait (rst_n === 1'b1);
    @(posedge clock_50);
    test_reset_defaults();
    test_decode();
    test_hex_display();
    test_uart_loopback();
    test_encoder();
    $display("summary: %0d tests passed, %0d tests failed", tests_passed, tests_failed);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clock_50);
      cycles++;
    end
    $display("timeout: run still going after %0d cycles", cycles);
    $display("TEST FAIL");
    $finish;
  end

endmodule

// File: soc_io.f
source/soc_map_pkg.sv
source/soc_io_pkg.sv
source/mem_select.sv
source/uart.sv
source/rgb_enc.sv
source/hexdisp.sv
source/soc_io.sv
test/clock_gen.sv
test/soc_io_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the soc_io testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f soc_io.f --top-module soc_io_tb \
  -Mdir obj_dir -o soc_io_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/soc_io_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAIL" "$LOG"; then
  exit 1
fi
if ! grep -q "TEST PASS" "$LOG"; then
  echo "simulation ended without a result line"
  exit 1
fi
exit 0
